// File: compile.f
rtl/rv_isa_pkg.sv
rtl/rv_ctrl_pkg.sv
rtl/rv_decode.sv
rtl/rv_regfile.sv
rtl/rv_execute.sv
rtl/rv_mem_access.sv
rtl/rv_result.sv
rtl/rv_core.sv
testbench/rv_core_sva.sv
testbench/tb_rv_core.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_rv_core -f compile.f -o sim_rv_core

sim_out=$(./obj_dir/sim_rv_core 2>&1) || true
echo "$sim_out"

if grep -qx "No errors" <<< "$sim_out"; then
  exit 0
fi
exit 1

// File: testbench/tb_rv_core.sv
`timescale 1ns/100ps
`default_nettype none

module tb_rv_core;
  import rv_isa_pkg::*;

  localparam word_t nop_inst    = 32'h0000_0013; // addi x0, x0, 0
  localparam word_t result_addr = 32'h0000_0000;
  localparam int    max_cycles  = 2000;

  logic       clk;
  logic       rst_n;
  word_t      inst;
  word_t      pc;
  word_t      mem_addr;
  logic       mem_rd_en;
  logic       mem_wr_en;
  logic [3:0] mem_wmask;
  word_t      mem_wdata;
  word_t      mem_rdata;

  word_t       rom [0:511];
  logic [7:0]  dmem [0:1023];
  logic [8:0]  n_inst;
  word_t       pc_off;
  word_t       end_pc;
  logic [31:0] lfsr_state;
  word_t       exp_q[$];
  string       name_q[$];
  word_t       exp_v;
  string       exp_name;
  int          err_cnt;
  int          timeout_cnt;
  int          cycles;

  rv_core rv_core_inst (
    .clk(clk), .rst_n(rst_n), .inst(inst), .pc(pc), .mem_addr(mem_addr),
    .mem_rd_en(mem_rd_en), .mem_wr_en(mem_wr_en), .mem_wmask(mem_wmask),
    .mem_wdata(mem_wdata), .mem_rdata(mem_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // instruction fetch and data reads are combinational
  assign pc_off    = pc - reset_pc;
  assign inst      = rst_n ? rom[pc_off[10:2]] : nop_inst;
  assign mem_rdata = {dmem[{mem_addr[9:2], 2'd3}], dmem[{mem_addr[9:2], 2'd2}],
                      dmem[{mem_addr[9:2], 2'd1}], dmem[{mem_addr[9:2], 2'd0}]};

  always @(posedge clk) begin
    if (mem_wr_en) begin
      for (logic [2:0] k = 0; k < 3'd4; k++) begin
        if (mem_wmask[k[1:0]]) begin
          dmem[{mem_addr[9:2], k[1:0]}] <= mem_wdata[{k[1:0], 3'b000} +: 8];
        end
      end
    end
  end

  // each sw to result_addr is one result in program order
  always @(negedge clk) begin
    if (rst_n && pc[1:0] != 2'b00) begin
      $display("pc %h is not word aligned", pc);
      err_cnt++;
    end
    if (rst_n && mem_wr_en && mem_addr == result_addr) begin
      if (exp_q.size() == 0) begin
        $display("unexpected result store of %h at pc %h", mem_wdata, pc);
        err_cnt++;
      end else begin
        exp_v    = exp_q.pop_front();
        exp_name = name_q.pop_front();
        if (mem_wdata !== exp_v) begin
          $display("[ERROR] %s: expected %h, actual %h", exp_name, exp_v, mem_wdata);
          err_cnt++;
        end
      end
    end
  end

  // galois lfsr with taps 32 22 2 1
  function automatic logic next_bit();
    logic b;
    b          = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (b) lfsr_state = lfsr_state ^ 32'h8020_0003;
    return b;
  endfunction

  function automatic word_t rand_bits(input int nbits);
    word_t v;
    v = '0;
    for (int k = 0; k < nbits; k++) v = {v[30:0], next_bit()};
    return v;
  endfunction

  function automatic word_t enc_r(input logic [6:0] f7, input reg_addr_t rs2, rs1,
                                  input logic [2:0] f3, input reg_addr_t rd);
    return {f7, rs2, rs1, f3, rd, op_reg};
  endfunction

  function automatic word_t enc_i(input logic [11:0] imm, input reg_addr_t rs1,
                                  input logic [2:0] f3, input reg_addr_t rd,
                                  input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic word_t enc_s(input logic [11:0] imm, input reg_addr_t rs2, rs1,
                                  input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], op_store};
  endfunction

  function automatic word_t enc_b(input logic [12:0] off, input reg_addr_t rs2, rs1,
                                  input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], op_branch};
  endfunction

  function automatic word_t enc_u(input logic [19:0] u, input reg_addr_t rd,
                                  input logic [6:0] op);
    return {u, rd, op};
  endfunction

  function automatic word_t enc_j(input logic [20:0] off, input reg_addr_t rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, op_jal};
  endfunction

  // reference results straight from the ISA definitions
  function automatic word_t alu_model(input logic [2:0] f3, input logic alt,
                                      input word_t a, input word_t b);
    word_t r;
    case (f3)
      f3_add:  r = alt ? a - b : a + b;
      f3_sll:  r = a << b[4:0];
      f3_slt:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      f3_sltu: r = (a < b) ? 32'd1 : 32'd0;
      f3_xor:  r = a ^ b;
      f3_sr:   r = alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      f3_or:   r = a | b;
      default: r = a & b;
    endcase
    return r;
  endfunction

  function automatic logic branch_model(input logic [2:0] f3, input word_t a, input word_t b);
    logic t;
    case (f3)
      f3_beq:  t = (a == b);
      f3_bne:  t = (a != b);
      f3_blt:  t = ($signed(a) < $signed(b));
      f3_bge:  t = ($signed(a) >= $signed(b));
      f3_bltu: t = (a < b);
      default: t = (a >= b);
    endcase
    return t;
  endfunction

  function automatic word_t cur_pc();
    return reset_pc + {21'd0, n_inst, 2'b00};
  endfunction

  task automatic emit(input word_t w);
    rom[n_inst] = w;
    n_inst++;
  endtask

  task automatic set_reg(input reg_addr_t rd, input word_t v);
    word_t hi;
    hi = v + 32'h800; // addi sign-extends its low 12 bits
    emit(enc_u(hi[31:12], rd, op_lui));
    emit(enc_i(v[11:0], rd, f3_add, rd, op_imm));
  endtask

  task automatic check_reg(input reg_addr_t rs, input word_t expected, input string name);
    emit(enc_s(12'd0, rs, 5'd0, f3_word));
    exp_q.push_back(expected);
    name_q.push_back(name);
  endtask

  task automatic alu_rr(input logic [2:0] f3, input logic alt, input word_t a, input word_t b,
                        input string name);
    emit(enc_r(alt ? f7_alt : 7'd0, 5'd2, 5'd1, f3, 5'd3));
    check_reg(5'd3, alu_model(f3, alt, a, b), name);
  endtask

  // shifts keep funct7 in imm[11:5]
  task automatic alu_ri(input logic [2:0] f3, input logic [11:0] imm, input word_t a,
                        input string name);
    word_t b;
    logic  alt;
    alt = (f3 == f3_sr) && imm[10];
    b   = (f3 == f3_sll || f3 == f3_sr) ? {27'd0, imm[4:0]} : {{20{imm[11]}}, imm};
    emit(enc_i(imm, 5'd1, f3, 5'd3, op_imm));
    check_reg(5'd3, alu_model(f3, alt, a, b), name);
  endtask

  task automatic build_alu();
    word_t       a, b, u, here;
    logic [11:0] imm;
    logic [4:0]  sh;
    a   = rand_bits(32);
    b   = rand_bits(32);
    imm = 12'(rand_bits(12));
    sh  = 5'(rand_bits(5));
    u   = rand_bits(20);
    set_reg(5'd1, a);
    set_reg(5'd2, b);
    alu_rr(f3_add, 1'b0, a, b, "add");
    alu_rr(f3_add, 1'b1, a, b, "sub");
    alu_rr(f3_sll, 1'b0, a, b, "sll");
    alu_rr(f3_slt, 1'b0, a, b, "slt");
    alu_rr(f3_sltu, 1'b0, a, b, "sltu");
    alu_rr(f3_xor, 1'b0, a, b, "xor");
    alu_rr(f3_sr, 1'b0, a, b, "srl");
    alu_rr(f3_sr, 1'b1, a, b, "sra");
    alu_rr(f3_or, 1'b0, a, b, "or");
    alu_rr(f3_and, 1'b0, a, b, "and");
    alu_ri(f3_add, imm, a, "addi");
    alu_ri(f3_slt, imm, a, "slti");
    alu_ri(f3_sltu, imm, a, "sltiu");
    alu_ri(f3_xor, imm, a, "xori");
    alu_ri(f3_or, imm, a, "ori");
    alu_ri(f3_and, imm, a, "andi");
    alu_ri(f3_sll, {7'd0, sh}, a, "slli");
    alu_ri(f3_sr, {7'd0, sh}, a, "srli");
    alu_ri(f3_sr, {f7_alt, sh}, a, "srai");
    emit(enc_u(u[19:0], 5'd3, op_lui));
    check_reg(5'd3, {u[19:0], 12'd0}, "lui");
    here = cur_pc();
    emit(enc_u(u[19:0], 5'd3, op_auipc));
    check_reg(5'd3, here + {u[19:0], 12'd0}, "auipc");
  endtask

  task automatic load_check(input logic [2:0] f3, input logic [1:0] off, input word_t mem_word,
                            input string name);
    logic [7:0]  b8;
    logic [15:0] h16;
    word_t       expected;
    b8  = 8'(mem_word >> {off, 3'b000});
    h16 = 16'(mem_word >> {off, 3'b000});
    case (f3)
      f3_byte:   expected = {{24{b8[7]}}, b8};
      f3_byte_u: expected = {24'd0, b8};
      f3_half:   expected = {{16{h16[15]}}, h16};
      f3_half_u: expected = {16'd0, h16};
      default:   expected = mem_word;
    endcase
    emit(enc_i({10'd0, off}, 5'd30, f3, 5'd6, op_load));
    check_reg(5'd6, expected, $sformatf("%s at offset %0d", name, off));
  endtask

  task automatic build_loads();
    word_t w, v, mem_word;
    w = rand_bits(32);
    v = rand_bits(32);
    set_reg(5'd30, 32'h0000_0100); // data word used by the loads
    set_reg(5'd4, w);
    set_reg(5'd5, v);
    emit(enc_s(12'd0, 5'd4, 5'd30, f3_byte));
    emit(enc_s(12'd1, 5'd5, 5'd30, f3_byte));
    emit(enc_s(12'd2, 5'd4, 5'd30, f3_half));
    mem_word = {w[15:0], v[7:0], w[7:0]};
    for (int k = 0; k < 4; k++) begin
      load_check(f3_byte, 2'(k), mem_word, "lb");
      load_check(f3_byte_u, 2'(k), mem_word, "lbu");
    end
    for (int k = 0; k < 4; k += 2) begin
      load_check(f3_half, 2'(k), mem_word, "lh");
      load_check(f3_half_u, 2'(k), mem_word, "lhu");
    end
    load_check(f3_word, 2'd0, mem_word, "lw");
  endtask

  // marker 1 in x7 when not taken, marker 2 in x8 when taken
  task automatic branch_case(input logic [2:0] f3, input word_t a, input word_t b,
                             input string name);
    logic taken;
    taken = branch_model(f3, a, b);
    emit(enc_b(13'd12, 5'd2, 5'd1, f3));
    emit(enc_s(12'd0, 5'd7, 5'd0, f3_word));
    emit(enc_j(21'd8, 5'd0));
    emit(enc_s(12'd0, 5'd8, 5'd0, f3_word));
    exp_q.push_back(taken ? 32'd2 : 32'd1);
    name_q.push_back($sformatf("%s %s", name, taken ? "taken" : "not taken"));
  endtask

  task automatic build_branches();
    word_t a, b, t;
    a = rand_bits(32);
    b = a ^ ((rand_bits(32) & 32'h7fff_ffff) | 32'd1); // same sign as a but never equal
    if (b < a) begin // a below b both signed and unsigned
      t = a;
      a = b;
      b = t;
    end
    set_reg(5'd7, 32'd1);
    set_reg(5'd8, 32'd2);
    for (int p = 0; p < 2; p++) begin
      set_reg(5'd1, a);
      set_reg(5'd2, (p == 0) ? a : b);
      branch_case(f3_beq, a, (p == 0) ? a : b, "beq");
      branch_case(f3_bne, a, (p == 0) ? a : b, "bne");
      branch_case(f3_blt, a, (p == 0) ? a : b, "blt");
      branch_case(f3_bge, a, (p == 0) ? a : b, "bge");
      branch_case(f3_bltu, a, (p == 0) ? a : b, "bltu");
      branch_case(f3_bgeu, a, (p == 0) ? a : b, "bgeu");
    end
  endtask

  task automatic build_jumps();
    word_t link, pc_j;
    link = cur_pc() + 32'd4;
    emit(enc_j(21'd8, 5'd11));
    emit(enc_s(12'd0, 5'd7, 5'd0, f3_word)); // skipped
    check_reg(5'd11, link, "jal link");
    pc_j = cur_pc() + 32'd8;
    set_reg(5'd9, pc_j + 32'd6); // +3 gives an odd sum and jalr clears bit 0
    emit(enc_i(12'd3, 5'd9, 3'b000, 5'd10, op_jalr));
    emit(enc_s(12'd0, 5'd7, 5'd0, f3_word)); // skipped
    check_reg(5'd10, pc_j + 32'd4, "jalr link");
  endtask

  initial begin
    rst_n       = 1'b0;
    err_cnt     = 0;
    timeout_cnt = 0;
    lfsr_state  = 32'h0a6e_d9e7;
    n_inst      = '0;
    for (logic [9:0] j = 0; j < 10'd512; j++) rom[j[8:0]] = nop_inst;
    for (logic [10:0] i = 0; i < 11'd1024; i++) dmem[i[9:0]] = i[7:0] ^ {6'd0, i[9:8]} ^ 8'ha5;
    emit(nop_inst); // first fetch after reset
    for (int r = 0; r < 3; r++) build_alu();
    build_loads();
    build_branches();
    build_jumps();
    end_pc = cur_pc();
    emit(enc_j(21'd0, 5'd0)); // spin here

    repeat (8) @(negedge clk);
    rst_n  = 1'b1;
    cycles = 0;
    while (pc != end_pc && cycles < max_cycles) begin
      @(negedge clk);
      cycles++;
    end
    if (pc != end_pc) begin
      $display("timeout waiting for the program to reach %h", end_pc);
      timeout_cnt++;
    end
    @(negedge clk);
    if (exp_q.size() != 0) begin
      $display("%0d expected result stores never happened", exp_q.size());
      err_cnt++;
    end
    $display("checks done: %0d errors, %0d timeouts", err_cnt, timeout_cnt);
    if (err_cnt == 0 && timeout_cnt == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: testbench/rv_core_sva.sv
`timescale 1ns/100ps
`default_nettype none

module rv_core_sva (
  input logic              clk,
  input logic              rst_n,
  input rv_isa_pkg::word_t inst,
  input rv_isa_pkg::word_t pc,
  input rv_isa_pkg::word_t mem_addr,
  input logic              mem_rd_en,
  input logic              mem_wr_en,
  input logic [3:0]        mem_wmask,
  input rv_isa_pkg::word_t mem_wdata,
  input rv_isa_pkg::word_t rs2_data
);
  import rv_isa_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic       seq_op;
  word_t      jal_tgt;
  logic [3:0] exp_mask;

  assign opcode  = inst[6:0];
  assign funct3  = inst[14:12];
  assign seq_op  = (opcode != op_branch) && (opcode != op_jal) && (opcode != op_jalr);
  assign jal_tgt = pc + {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

  // sb one lane, sh an even lane pair, sw all four when aligned
  always_comb begin
    case ({funct3, mem_addr[1:0]})
      {f3_byte, 2'b00}: exp_mask = 4'b0001;
      {f3_byte, 2'b01}: exp_mask = 4'b0010;
      {f3_byte, 2'b10}: exp_mask = 4'b0100;
      {f3_byte, 2'b11}: exp_mask = 4'b1000;
      {f3_half, 2'b00}: exp_mask = 4'b0011;
      {f3_half, 2'b10}: exp_mask = 4'b1100;
      {f3_word, 2'b00}: exp_mask = 4'b1111;
      default:          exp_mask = 4'b0000; // misaligned
    endcase
  end

  reset_pc_held: assert property (@(posedge clk)
    !rst_n |=> pc == reset_pc && !mem_rd_en && !mem_wr_en)
    else $error("pc or memory enables wrong right after a reset cycle");

  reset_mem_idle: assert property (@(posedge clk) !rst_n |-> !mem_rd_en && !mem_wr_en)
    else $error("memory enable active during reset");

  seq_pc: assert property (@(posedge clk) rst_n && seq_op |=> pc == $past(pc) + 32'd4)
    else $error("pc did not advance by 4");

  jal_pc: assert property (@(posedge clk) rst_n && opcode == op_jal |=> pc == $past(jal_tgt))
    else $error("jal landed off its target");

  store_mask: assert property (@(posedge clk) rst_n && mem_wr_en |-> mem_wmask == exp_mask)
    else $error("store byte mask does not match size and address");

  sw_data: assert property (@(posedge clk)
    rst_n && mem_wr_en && funct3 == f3_word |-> mem_wdata == rs2_data)
    else $error("sw write data differs from rs2");

endmodule

bind rv_core rv_core_sva rv_core_sva_inst (
  .clk(clk), .rst_n(rst_n), .inst(inst), .pc(pc), .mem_addr(mem_addr),
  .mem_rd_en(mem_rd_en), .mem_wr_en(mem_wr_en), .mem_wmask(mem_wmask),
  .mem_wdata(mem_wdata), .rs2_data(rs2_data)
);

`default_nettype wire

// File: rtl/rv_core.sv
`timescale 1ns/100ps
`default_nettype none

module rv_core (
  input  logic              clk,
  input  logic              rst_n,
  input  rv_isa_pkg::word_t inst,
  output rv_isa_pkg::word_t pc,
  output rv_isa_pkg::word_t mem_addr,
  output logic              mem_rd_en,
  output logic              mem_wr_en,
  output logic [3:0]        mem_wmask,
  output rv_isa_pkg::word_t mem_wdata,
  input  rv_isa_pkg::word_t mem_rdata
);
  import rv_isa_pkg::*;

  reg_addr_t rs1_addr, rs2_addr, rd_addr;
  logic [2:0] funct3;
  word_t      imm;
  logic       reg_we;

  rv_ctrl_pkg::alu_op_e   alu_op;
  rv_ctrl_pkg::op_b_sel_e op_b_sel;
  rv_ctrl_pkg::tgt_base_e tgt_base;
  rv_ctrl_pkg::wb_sel_e   wb_sel;
  rv_ctrl_pkg::pc_sel_e   pc_sel;

  word_t rs1_data, rs2_data;
  word_t alu_out, target;
  logic  cmp_true;
  word_t load_data;
  word_t wdata; // register write-back

  rv_decode u_decode (
    .inst(inst), .rs1_addr(rs1_addr), .rs2_addr(rs2_addr), .rd_addr(rd_addr),
    .funct3(funct3), .imm(imm), .alu_op(alu_op), .op_b_sel(op_b_sel),
    .tgt_base(tgt_base), .wb_sel(wb_sel), .pc_sel(pc_sel), .reg_we(reg_we),
    .mem_rd_en(mem_rd_en), .mem_wr_en(mem_wr_en)
  );

  rv_regfile u_regfile (
    .clk(clk), .we(reg_we), .waddr(rd_addr), .raddr1(rs1_addr), .raddr2(rs2_addr),
    .wdata(wdata), .rdata1(rs1_data), .rdata2(rs2_data)
  );

  rv_execute u_execute (
    .rs1_data(rs1_data), .rs2_data(rs2_data), .imm(imm), .pc(pc), .funct3(funct3),
    .alu_op(alu_op), .op_b_sel(op_b_sel), .tgt_base(tgt_base),
    .alu_out(alu_out), .target(target), .cmp_true(cmp_true)
  );

  rv_mem_access u_mem_access (
    .addr(alu_out), .store_data(rs2_data), .mem_rdata(mem_rdata), .funct3(funct3),
    .mem_wmask(mem_wmask), .mem_wdata(mem_wdata), .load_data(load_data)
  );

  rv_result u_result (
    .clk(clk), .rst_n(rst_n), .wb_sel(wb_sel), .pc_sel(pc_sel), .alu_out(alu_out),
    .load_data(load_data), .imm(imm), .target(target), .cmp_true(cmp_true),
    .wdata(wdata), .pc(pc)
  );

  assign mem_addr = alu_out; // rs1 + imm for loads and stores

endmodule

`default_nettype wire

// File: rtl/rv_result.sv
`timescale 1ns/100ps
`default_nettype none

module rv_result (
  input  logic                 clk,
  input  logic                 rst_n,
  input  rv_ctrl_pkg::wb_sel_e wb_sel,
  input  rv_ctrl_pkg::pc_sel_e pc_sel,
  input  rv_isa_pkg::word_t    alu_out,
  input  rv_isa_pkg::word_t    load_data,
  input  rv_isa_pkg::word_t    imm,
  input  rv_isa_pkg::word_t    target,
  input  logic                 cmp_true,
  output rv_isa_pkg::word_t    wdata,
  output rv_isa_pkg::word_t    pc
);
  import rv_isa_pkg::*;
  import rv_ctrl_pkg::*;

  word_t pc_plus4;
  word_t next_pc;

  assign pc_plus4 = pc + 32'd4;

  always_comb begin
    case (wb_sel)
      wb_load:   wdata = load_data;
      wb_link:   wdata = pc_plus4; // return address for jal / jalr
      wb_imm:    wdata = imm;
      wb_target: wdata = target;
      default:   wdata = alu_out;
    endcase
  end

  always_comb begin
    case (pc_sel)
      pc_jump:   next_pc = target;
      pc_branch: next_pc = cmp_true ? target : pc_plus4;
      default:   next_pc = pc_plus4;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc <= reset_pc;
    end else begin
      pc <= next_pc;
    end
  end

endmodule

`default_nettype wire

// File: rtl/rv_mem_access.sv
`timescale 1ns/100ps
`default_nettype none

module rv_mem_access (
  input  rv_isa_pkg::word_t addr,
  input  rv_isa_pkg::word_t store_data,
  input  rv_isa_pkg::word_t mem_rdata,
  input  logic [2:0]        funct3,
  output logic [3:0]        mem_wmask,
  output rv_isa_pkg::word_t mem_wdata,
  output rv_isa_pkg::word_t load_data
);
  import rv_isa_pkg::*;

  logic [1:0] lane;
  logic [4:0] lane_bits;
  word_t      rd_shifted;

  assign lane      = addr[1:0];
  assign lane_bits = {lane, 3'b000};

  // store side, data moves up to its byte lane
  assign mem_wdata = store_data << lane_bits;

  always_comb begin
    case (funct3)
      f3_byte: mem_wmask = 4'b0001 << lane;
      f3_half: mem_wmask = lane[0] ? 4'b0000 : (4'b0011 << lane);
      f3_word: mem_wmask = (lane == 2'b00) ? 4'b1111 : 4'b0000;
      default: mem_wmask = 4'b0000;
    endcase
  end

  // load side, addressed lane down to bit 0 then extend
  assign rd_shifted = mem_rdata >> lane_bits;

  always_comb begin
    case (funct3)
      f3_byte:   load_data = {{24{rd_shifted[7]}}, rd_shifted[7:0]};
      f3_byte_u: load_data = {24'd0, rd_shifted[7:0]};
      f3_half: begin
        load_data = lane[0] ? '0 : {{16{rd_shifted[15]}}, rd_shifted[15:0]};
      end
      f3_half_u: load_data = lane[0] ? '0 : {16'd0, rd_shifted[15:0]};
      f3_word:   load_data = (lane == 2'b00) ? mem_rdata : '0;
      default:   load_data = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: rtl/rv_execute.sv
`timescale 1ns/100ps
`default_nettype none

module rv_execute (
  input  rv_isa_pkg::word_t      rs1_data,
  input  rv_isa_pkg::word_t      rs2_data,
  input  rv_isa_pkg::word_t      imm,
  input  rv_isa_pkg::word_t      pc,
  input  logic [2:0]             funct3,
  input  rv_ctrl_pkg::alu_op_e   alu_op,
  input  rv_ctrl_pkg::op_b_sel_e op_b_sel,
  input  rv_ctrl_pkg::tgt_base_e tgt_base,
  output rv_isa_pkg::word_t      alu_out,
  output rv_isa_pkg::word_t      target,
  output logic                   cmp_true
);
  import rv_isa_pkg::*;
  import rv_ctrl_pkg::*;

  word_t           op_b;
  logic [xlen:0]   diff_full; // rs1 - op_b with carry out
  word_t           diff;
  logic            carry;
  logic            zero;
  logic            sign;
  logic            ovf;
  logic            lt;
  logic            ltu;
  logic [4:0]      shamt;
  word_t           tgt_base_val;
  word_t           tgt_sum;

  assign op_b  = (op_b_sel == b_imm) ? imm : rs2_data;
  assign shamt = op_b[4:0];

  // one subtractor feeds sub, slt/sltu and the branch compare
  assign diff_full = {1'b0, rs1_data} + {1'b0, ~op_b} + {{xlen{1'b0}}, 1'b1};
  assign diff      = diff_full[xlen-1:0];
  assign carry     = diff_full[xlen]; // no borrow when set
  assign zero      = (diff == '0);
  assign sign      = diff[xlen-1];
  assign ovf       = (rs1_data[xlen-1] != op_b[xlen-1]) && (sign != rs1_data[xlen-1]);
  assign lt        = sign ^ ovf;
  assign ltu       = ~carry;

  always_comb begin
    case (alu_op)
      alu_add:  alu_out = rs1_data + op_b;
      alu_sub:  alu_out = diff;
      alu_sll:  alu_out = rs1_data << shamt;
      alu_slt:  alu_out = {{(xlen-1){1'b0}}, lt};
      alu_sltu: alu_out = {{(xlen-1){1'b0}}, ltu};
      alu_xor:  alu_out = rs1_data ^ op_b;
      alu_srl:  alu_out = rs1_data >> shamt;
      alu_sra:  alu_out = word_t'($signed(rs1_data) >>> shamt);
      alu_or:   alu_out = rs1_data | op_b;
      default:  alu_out = rs1_data & op_b;
    endcase
  end

  always_comb begin
    case (funct3)
      f3_beq:  cmp_true = zero;
      f3_bne:  cmp_true = ~zero;
      f3_blt:  cmp_true = lt;
      f3_bge:  cmp_true = ~lt;
      f3_bltu: cmp_true = ltu;
      f3_bgeu: cmp_true = ~ltu;
      default: cmp_true = 1'b0;
    endcase
  end

  // pc + imm for jal, branches and auipc, rs1 + imm for jalr
  assign tgt_base_val = (tgt_base == base_rs1) ? rs1_data : pc;
  assign tgt_sum      = tgt_base_val + imm;
  assign target       = {tgt_sum[xlen-1:1], tgt_sum[0] & (tgt_base != base_rs1)};

endmodule

`default_nettype wire

// File: rtl/rv_regfile.sv
`timescale 1ns/100ps
`default_nettype none

module rv_regfile (
  input  logic                  clk,
  input  logic                  we,
  input  rv_isa_pkg::reg_addr_t waddr,
  input  rv_isa_pkg::reg_addr_t raddr1,
  input  rv_isa_pkg::reg_addr_t raddr2,
  input  rv_isa_pkg::word_t     wdata,
  output rv_isa_pkg::word_t     rdata1,
  output rv_isa_pkg::word_t     rdata2
);

  // x1..x31, x0 has no storage
  rv_isa_pkg::word_t regs [1:31];

  always_ff @(posedge clk) begin
    if (we && waddr != '0) begin
      regs[waddr] <= wdata;
    end
  end

  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
  assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

// File: rtl/rv_decode.sv
`timescale 1ns/100ps
`default_nettype none

module rv_decode (
  input  rv_isa_pkg::word_t      inst,
  output rv_isa_pkg::reg_addr_t  rs1_addr,
  output rv_isa_pkg::reg_addr_t  rs2_addr,
  output rv_isa_pkg::reg_addr_t  rd_addr,
  output logic [2:0]             funct3,
  output rv_isa_pkg::word_t      imm,
  output rv_ctrl_pkg::alu_op_e   alu_op,
  output rv_ctrl_pkg::op_b_sel_e op_b_sel,
  output rv_ctrl_pkg::tgt_base_e tgt_base,
  output rv_ctrl_pkg::wb_sel_e   wb_sel,
  output rv_ctrl_pkg::pc_sel_e   pc_sel,
  output logic                   reg_we,
  output logic                   mem_rd_en,
  output logic                   mem_wr_en
);
  import rv_isa_pkg::*;
  import rv_ctrl_pkg::*;

  logic [6:0] opcode;
  logic [6:0] funct7;
  logic       alt;
  word_t      imm_i, imm_s, imm_b, imm_u, imm_j, imm_sh;

  // alt picks sub only for the reg form, sra for both
  function automatic alu_op_e alu_from_f3(input logic [2:0] f3, input logic alt_sel,
                                          input logic is_reg);
    alu_op_e op;
    case (f3)
      f3_add:  op = (alt_sel && is_reg) ? alu_sub : alu_add;
      f3_sll:  op = alu_sll;
      f3_slt:  op = alu_slt;
      f3_sltu: op = alu_sltu;
      f3_xor:  op = alu_xor;
      f3_sr:   op = alt_sel ? alu_sra : alu_srl;
      f3_or:   op = alu_or;
      default: op = alu_and;
    endcase
    return op;
  endfunction

  assign opcode   = inst[6:0];
  assign rd_addr  = inst[11:7];
  assign funct3   = inst[14:12];
  assign rs1_addr = inst[19:15];
  assign rs2_addr = inst[24:20];
  assign funct7   = inst[31:25];
  assign alt      = (funct7 == f7_alt);

  assign imm_i  = {{20{inst[31]}}, inst[31:20]};
  assign imm_s  = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b  = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u  = {inst[31:12], 12'h000};
  assign imm_j  = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
  assign imm_sh = {27'd0, inst[24:20]}; // shamt only

  always_comb begin
    imm       = '0;
    alu_op    = alu_add;
    op_b_sel  = b_reg;
    tgt_base  = base_pc;
    wb_sel    = wb_alu;
    pc_sel    = pc_seq;
    reg_we    = 1'b0;
    mem_rd_en = 1'b0;
    mem_wr_en = 1'b0;
    case (opcode)
      op_reg: begin
        alu_op = alu_from_f3(funct3, alt, 1'b1);
        reg_we = 1'b1;
      end
      op_imm: begin
        imm      = (funct3 == f3_sll || funct3 == f3_sr) ? imm_sh : imm_i;
        alu_op   = alu_from_f3(funct3, alt, 1'b0);
        op_b_sel = b_imm;
        reg_we   = 1'b1;
      end
      op_load: begin
        imm       = imm_i;
        op_b_sel  = b_imm; // address = rs1 + imm
        wb_sel    = wb_load;
        reg_we    = 1'b1;
        mem_rd_en = 1'b1;
      end
      op_store: begin
        imm       = imm_s;
        op_b_sel  = b_imm;
        mem_wr_en = 1'b1;
      end
      op_branch: begin
        imm    = imm_b; // compare rs1 against rs2, target from pc
        pc_sel = pc_branch;
      end
      op_jal: begin
        imm    = imm_j;
        wb_sel = wb_link;
        pc_sel = pc_jump;
        reg_we = 1'b1;
      end
      op_jalr: begin
        imm      = imm_i;
        tgt_base = base_rs1;
        wb_sel   = wb_link;
        pc_sel   = pc_jump;
        reg_we   = 1'b1;
      end
      op_lui: begin
        imm    = imm_u;
        wb_sel = wb_imm;
        reg_we = 1'b1;
      end
      op_auipc: begin
        imm    = imm_u;
        wb_sel = wb_target;
        reg_we = 1'b1;
      end
      default: ; // unknown opcode acts as a nop
    endcase
  end

endmodule

`default_nettype wire

// File: rtl/rv_ctrl_pkg.sv
`default_nettype none

package rv_ctrl_pkg;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and
  } alu_op_e;

  // second alu operand
  typedef enum logic {b_reg, b_imm} op_b_sel_e;

  // base of the target adder, rs1 only for jalr
  typedef enum logic {base_pc, base_rs1} tgt_base_e;

  typedef enum logic [2:0] {
    wb_alu,
    wb_load,
    wb_link,   // pc + 4
    wb_imm,    // lui
    wb_target  // auipc
  } wb_sel_e;

  typedef enum logic [1:0] {pc_seq, pc_jump, pc_branch} pc_sel_e;

endpackage

`default_nettype wire

// File: rtl/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;

  typedef logic [xlen-1:0]       word_t;
  typedef logic [reg_addr_w-1:0] reg_addr_t;

  localparam word_t reset_pc = 32'h8000_0000;

  // major opcodes, inst[6:0]
  localparam logic [6:0] op_reg    = 7'b011_0011;
  localparam logic [6:0] op_imm    = 7'b001_0011;
  localparam logic [6:0] op_load   = 7'b000_0011;
  localparam logic [6:0] op_store  = 7'b010_0011;
  localparam logic [6:0] op_branch = 7'b110_0011;
  localparam logic [6:0] op_jal    = 7'b110_1111;
  localparam logic [6:0] op_jalr   = 7'b110_0111;
  localparam logic [6:0] op_lui    = 7'b011_0111;
  localparam logic [6:0] op_auipc  = 7'b001_0111;

  // alu funct3, shared by reg and imm forms
  localparam logic [2:0] f3_add  = 3'b000;
  localparam logic [2:0] f3_sll  = 3'b001;
  localparam logic [2:0] f3_slt  = 3'b010;
  localparam logic [2:0] f3_sltu = 3'b011;
  localparam logic [2:0] f3_xor  = 3'b100;
  localparam logic [2:0] f3_sr   = 3'b101; // srl or sra, picked by funct7
  localparam logic [2:0] f3_or   = 3'b110;
  localparam logic [2:0] f3_and  = 3'b111;

  // branch conditions
  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

  // load / store access size
  localparam logic [2:0] f3_byte   = 3'b000;
  localparam logic [2:0] f3_half   = 3'b001;
  localparam logic [2:0] f3_word   = 3'b010;
  localparam logic [2:0] f3_byte_u = 3'b100;
  localparam logic [2:0] f3_half_u = 3'b101;

  localparam logic [6:0] f7_alt = 7'b010_0000; // sub, sra

endpackage

`default_nettype wire
